// File: logic/lsuConfigPkg.sv
package lsuConfigPkg;

    // default cache geometry
    parameter int defNumWays = 2;
    parameter int defNumSets = 16;
    parameter int defLineWords = 4;

    // byte address width of the core
    parameter int addrWidth = 32;

    // width of the load tag and store id carried through the pipelines
    parameter int idWidth = 8;

    // address fields for the default geometry
    parameter int defWayWidth = $clog2(defNumWays);
    parameter int defIndexWidth = $clog2(defNumSets);
    parameter int defWordIdxWidth = $clog2(defLineWords);
    parameter int defOffsetWidth = defWordIdxWidth + 2;
    parameter int defLineAddrWidth = addrWidth - defOffsetWidth;
    parameter int defTagWidth = defLineAddrWidth - defIndexWidth;

    // cache line number as seen by the memory controller, way above set
    parameter int defLineIdWidth = defWayWidth + defIndexWidth;

endpackage

// File: logic/lsuTypesPkg.sv
package lsuTypesPkg;

    // commands to the memory controller
    typedef enum logic [1:0] {
        cmdNone,
        cmdReplace,
        cmdCopyIn
    } memCmd;

    // transfer engine states
    typedef enum logic [1:0] {
        idle,
        issue,
        waitFill
    } arbState;

    // access size of a load
    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } ldSize;

endpackage

// File: logic/cacheArrays.sv
`timescale 1ns/1ns

module cacheArrays #(
    parameter int numWays = lsuConfigPkg::defNumWays,
    parameter int numSets = lsuConfigPkg::defNumSets,
    parameter int lineWords = lsuConfigPkg::defLineWords,
    localparam int wayWidth = $clog2(numWays),
    localparam int indexWidth = $clog2(numSets),
    localparam int wordIdxWidth = $clog2(lineWords),
    localparam int tagWidth = lsuConfigPkg::addrWidth - indexWidth - wordIdxWidth - 2
) (
    input  logic clk,
    input  logic rst,

    input  logic ldRdEn,
    input  logic [indexWidth+wordIdxWidth-1:0] ldRdAddr,
    output logic [numWays-1:0][tagWidth-1:0] ldTags,
    output logic [numWays-1:0] ldTagValid,
    output logic [numWays-1:0][31:0] ldWords,

    input  logic stRdEn,
    input  logic [indexWidth-1:0] stRdAddr,
    output logic [numWays-1:0][tagWidth-1:0] stTags,
    output logic [numWays-1:0] stTagValid,

    input  logic [indexWidth-1:0] vicSet,
    input  logic [wayWidth-1:0] vicWay,
    output logic [tagWidth-1:0] vicTag,
    output logic vicValid,
    output logic vicDirty,

    input  logic tagWe,
    input  logic [indexWidth-1:0] tagSet,
    input  logic [wayWidth-1:0] tagWay,
    input  logic [tagWidth-1:0] tagValue,

    input  logic dataWe,
    input  logic [indexWidth-1:0] dataSet,
    input  logic [wayWidth-1:0] dataWay,
    input  logic [wordIdxWidth-1:0] dataWordIdx,
    input  logic [31:0] dataWrite,
    input  logic [3:0] dataMask,

    input  logic fillEn,
    input  logic [wayWidth-1:0] fillWay,
    input  logic [indexWidth-1:0] fillSet,
    input  logic [wordIdxWidth-1:0] fillWordIdx,
    input  logic [31:0] fillData
);

    logic [tagWidth-1:0] tagMem [numWays][numSets];
    logic [31:0] dataMem [numWays][numSets][lineWords];
    logic [numWays-1:0][numSets-1:0] validBits;
    logic [numWays-1:0][numSets-1:0] dirtyBits;

    logic [indexWidth-1:0] ldSet;
    logic [wordIdxWidth-1:0] ldWordIdx;

    assign ldSet = ldRdAddr[indexWidth+wordIdxWidth-1:wordIdxWidth];
    assign ldWordIdx = ldRdAddr[wordIdxWidth-1:0];

    // a tag write installs a new clean line, and wins over a store to the same line
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (dataWe) begin
                dirtyBits[dataWay][dataSet] <= 1'b1;
            end
            if (tagWe) begin
                validBits[tagWay][tagSet] <= 1'b1;
                dirtyBits[tagWay][tagSet] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tagWe) begin
            tagMem[tagWay][tagSet] <= tagValue;
        end
    end

    // byte-masked store first, refill words last
    always_ff @(posedge clk) begin
        if (dataWe) begin
            for (int b = 0; b < 4; b++) begin
                if (dataMask[b]) begin
                    dataMem[dataWay][dataSet][dataWordIdx][8*b +: 8] <= dataWrite[8*b +: 8];
                end
            end
        end
        if (fillEn) begin
            dataMem[fillWay][fillSet][fillWordIdx] <= fillData;
        end
    end

    // registered reads, all ways at once
    always_ff @(posedge clk) begin
        if (ldRdEn) begin
            for (int w = 0; w < numWays; w++) begin
                ldTags[w] <= tagMem[w][ldSet];
                ldTagValid[w] <= validBits[w][ldSet];
                ldWords[w] <= dataMem[w][ldSet][ldWordIdx];
            end
        end
        if (stRdEn) begin
            for (int w = 0; w < numWays; w++) begin
                stTags[w] <= tagMem[w][stRdAddr];
                stTagValid[w] <= validBits[w][stRdAddr];
            end
        end
    end

    // victim lookup is combinational for the arbiter
    assign vicTag = tagMem[vicWay][vicSet];
    assign vicValid = validBits[vicWay][vicSet];
    // a store landing on the victim this cycle makes it dirty too
    assign vicDirty = dirtyBits[vicWay][vicSet]
        | (dataWe && dataWay == vicWay && dataSet == vicSet);

endmodule

// File: logic/loadPipe.sv
`timescale 1ns/1ns

module loadPipe #(
    parameter int numWays = lsuConfigPkg::defNumWays,
    parameter int numSets = lsuConfigPkg::defNumSets,
    parameter int lineWords = lsuConfigPkg::defLineWords,
    localparam int indexWidth = $clog2(numSets),
    localparam int wordIdxWidth = $clog2(lineWords),
    localparam int offsetWidth = wordIdxWidth + 2,
    localparam int lineAddrWidth = lsuConfigPkg::addrWidth - offsetWidth,
    localparam int tagWidth = lineAddrWidth - indexWidth
) (
    input  logic clk,
    input  logic rst,

    input  logic ldValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] ldAddr,
    input  lsuTypesPkg::ldSize ldSize,
    input  logic ldSigned,
    input  logic [lsuConfigPkg::idWidth-1:0] ldTag,

    output logic rdEn,
    output logic [indexWidth+wordIdxWidth-1:0] rdAddr,
    input  logic [numWays-1:0][tagWidth-1:0] tags,
    input  logic [numWays-1:0] tagValid,
    input  logic [numWays-1:0][31:0] words,

    input  logic xferValid,
    input  logic [lineAddrWidth-1:0] xferLine,

    output logic ldResValid,
    output logic [lsuConfigPkg::idWidth-1:0] ldResTag,
    output logic [31:0] ldResult,
    output logic ldFail,

    output logic missValid,
    output logic [lsuConfigPkg::addrWidth-1:0] missAddr
);

    import lsuConfigPkg::*;
    import lsuTypesPkg::*;

    logic valid1, valid2;
    logic [addrWidth-1:0] addr1, addr2;
    lsuTypesPkg::ldSize size1, size2;
    logic signed1, signed2;
    logic [idWidth-1:0] tag1, tag2;
    logic hit1, hit2;
    logic [31:0] word1, word2;
    logic inXfer;

    // set and word index are adjacent in the address
    assign rdEn = ldValid;
    assign rdAddr = ldAddr[offsetWidth+indexWidth-1:2];

    // stage 1 compares the tags of all ways
    always_comb begin
        hit1 = 1'b0;
        word1 = words[0];
        for (int w = 0; w < numWays; w++) begin
            if (tagValid[w] && tags[w] == addr1[addrWidth-1 -: tagWidth]) begin
                hit1 = 1'b1;
                word1 = words[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end else begin
            valid1 <= ldValid;
            valid2 <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        addr1 <= ldAddr;
        size1 <= ldSize;
        signed1 <= ldSigned;
        tag1 <= ldTag;
        addr2 <= addr1;
        size2 <= size1;
        signed2 <= signed1;
        tag2 <= tag1;
        hit2 <= hit1;
        word2 <= word1;
    end

    // stage 2, a line still being filled is not usable
    assign inXfer = xferValid && addr2[addrWidth-1:offsetWidth] == xferLine;

    assign ldResValid = valid2 && hit2 && !inXfer;
    assign ldFail = valid2 && !(hit2 && !inXfer);
    assign ldResTag = tag2;
    assign missValid = valid2 && !hit2;
    assign missAddr = addr2;

    always_comb begin
        logic [7:0] byteSel;
        logic [15:0] halfSel;
        byteSel = word2[8*addr2[1:0] +: 8];
        halfSel = word2[16*addr2[1] +: 16];
        case (size2)
            sizeByte: ldResult = {{24{signed2 & byteSel[7]}}, byteSel};
            sizeHalf: ldResult = {{16{signed2 & halfSel[15]}}, halfSel};
            default: ldResult = word2;
        endcase
    end

endmodule

// File: logic/storePipe.sv
`timescale 1ns/1ns

module storePipe #(
    parameter int numWays = lsuConfigPkg::defNumWays,
    parameter int numSets = lsuConfigPkg::defNumSets,
    parameter int lineWords = lsuConfigPkg::defLineWords,
    localparam int wayWidth = $clog2(numWays),
    localparam int indexWidth = $clog2(numSets),
    localparam int wordIdxWidth = $clog2(lineWords),
    localparam int offsetWidth = wordIdxWidth + 2,
    localparam int lineAddrWidth = lsuConfigPkg::addrWidth - offsetWidth,
    localparam int tagWidth = lineAddrWidth - indexWidth
) (
    input  logic clk,
    input  logic rst,

    input  logic stValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] stAddr,
    input  logic [31:0] stData,
    input  logic [3:0] stMask,
    input  logic [lsuConfigPkg::idWidth-1:0] stId,

    output logic rdEn,
    output logic [indexWidth-1:0] rdAddr,
    input  logic [numWays-1:0][tagWidth-1:0] tags,
    input  logic [numWays-1:0] tagValid,

    input  logic xferValid,
    input  logic [lineAddrWidth-1:0] xferLine,

    output logic dataWe,
    output logic [indexWidth-1:0] dataSet,
    output logic [wayWidth-1:0] dataWay,
    output logic [wordIdxWidth-1:0] dataWordIdx,
    output logic [31:0] dataWrite,
    output logic [3:0] dataMask,

    output logic stAckValid,
    output logic [lsuConfigPkg::idWidth-1:0] stAckId,
    output logic stAckFail,

    output logic missValid,
    output logic [lsuConfigPkg::addrWidth-1:0] missAddr
);

    import lsuConfigPkg::*;

    logic valid1, valid2;
    logic [addrWidth-1:0] addr1, addr2;
    logic [31:0] data1, data2;
    logic [3:0] mask1, mask2;
    logic [idWidth-1:0] id1, id2;
    logic hit1, hit2;
    logic [wayWidth-1:0] way1, way2;
    logic writeOk;

    assign rdEn = stValid;
    assign rdAddr = stAddr[offsetWidth +: indexWidth];

    // stage 1 finds the hitting way
    always_comb begin
        hit1 = 1'b0;
        way1 = '0;
        for (int w = 0; w < numWays; w++) begin
            if (tagValid[w] && tags[w] == addr1[addrWidth-1 -: tagWidth]) begin
                hit1 = 1'b1;
                way1 = wayWidth'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end else begin
            valid1 <= stValid;
            valid2 <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        addr1 <= stAddr;
        data1 <= stData;
        mask1 <= stMask;
        id1 <= stId;
        addr2 <= addr1;
        data2 <= data1;
        mask2 <= mask1;
        id2 <= id1;
        hit2 <= hit1;
        way2 <= way1;
    end

    // stores only land on a present line that is not being refilled
    assign writeOk = hit2 && !(xferValid && addr2[addrWidth-1:offsetWidth] == xferLine);

    assign dataWe = valid2 && writeOk;
    assign dataSet = addr2[offsetWidth +: indexWidth];
    assign dataWay = way2;
    assign dataWordIdx = addr2[offsetWidth-1:2];
    assign dataWrite = data2;
    assign dataMask = mask2;

    assign stAckValid = valid2;
    assign stAckId = id2;
    assign stAckFail = valid2 && !writeOk;

    // misses still go to the arbiter so a retry can hit
    assign missValid = valid2 && !hit2;
    assign missAddr = addr2;

endmodule

// File: logic/missArbiter.sv
`timescale 1ns/1ns

module missArbiter #(
    parameter int numWays = lsuConfigPkg::defNumWays,
    parameter int numSets = lsuConfigPkg::defNumSets,
    parameter int lineWords = lsuConfigPkg::defLineWords,
    localparam int wayWidth = $clog2(numWays),
    localparam int indexWidth = $clog2(numSets),
    localparam int offsetWidth = $clog2(lineWords) + 2,
    localparam int lineAddrWidth = lsuConfigPkg::addrWidth - offsetWidth,
    localparam int tagWidth = lineAddrWidth - indexWidth
) (
    input  logic clk,
    input  logic rst,

    input  logic ldMissValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] ldMissAddr,
    input  logic stMissValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] stMissAddr,

    output logic [indexWidth-1:0] vicSet,
    output logic [wayWidth-1:0] vicWay,
    input  logic [tagWidth-1:0] vicTag,
    input  logic vicValid,
    input  logic vicDirty,

    output logic tagWe,
    output logic [indexWidth-1:0] tagSet,
    output logic [wayWidth-1:0] tagWay,
    output logic [tagWidth-1:0] tagValue,

    output logic xferValid,
    output logic [lineAddrWidth-1:0] xferLine,
    output logic [wayWidth-1:0] fillWay,
    output logic [indexWidth-1:0] fillSet,

    output lsuTypesPkg::memCmd memCmd,
    output logic [wayWidth+indexWidth-1:0] memCacheLine,
    output logic [lsuConfigPkg::addrWidth-1:0] memReadAddr,
    output logic [lsuConfigPkg::addrWidth-1:0] memWriteAddr,

    input  logic memStall,
    input  logic memDone
);

    import lsuConfigPkg::*;
    import lsuTypesPkg::*;

    arbState state;
    logic [wayWidth-1:0] wayCnt;
    logic [addrWidth-1:0] pickAddr;
    logic take;

    // loads have priority over stores
    assign pickAddr = ldMissValid ? ldMissAddr : stMissAddr;
    assign take = state == idle && (ldMissValid || stMissValid);

    // round-robin victim in the set of the miss
    assign vicSet = pickAddr[offsetWidth +: indexWidth];
    assign vicWay = wayCnt;

    // the new tag goes in right away, the line stays blocked until memDone
    assign tagWe = take;
    assign tagSet = vicSet;
    assign tagWay = wayCnt;
    assign tagValue = pickAddr[addrWidth-1 -: tagWidth];

    assign xferValid = state != idle;
    assign xferLine = memReadAddr[addrWidth-1:offsetWidth];
    assign fillWay = memCacheLine[indexWidth +: wayWidth];
    assign fillSet = memCacheLine[indexWidth-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            memCmd <= cmdNone;
            wayCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        state <= issue;
                        wayCnt <= wayCnt + 1'b1;
                        // only a dirty victim needs writing back
                        memCmd <= (vicValid && vicDirty) ? cmdReplace : cmdCopyIn;
                    end
                end
                issue: begin
                    // command holds under back-pressure
                    if (!memStall) begin
                        memCmd <= cmdNone;
                        state <= waitFill;
                    end
                end
                waitFill: begin
                    if (memDone) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // transfer addresses, line aligned
    always_ff @(posedge clk) begin
        if (take) begin
            memCacheLine <= {wayCnt, vicSet};
            memReadAddr <= {pickAddr[addrWidth-1:offsetWidth], {offsetWidth{1'b0}}};
            memWriteAddr <= {vicTag, vicSet, {offsetWidth{1'b0}}};
        end
    end

endmodule

// File: logic/cacheLsu.sv
`timescale 1ns/1ns

module cacheLsu (
    input  logic clk,
    input  logic rst,

    input  logic ldValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] ldAddr,
    input  lsuTypesPkg::ldSize ldSize,
    input  logic ldSigned,
    input  logic [lsuConfigPkg::idWidth-1:0] ldTag,

    output logic ldResValid,
    output logic [lsuConfigPkg::idWidth-1:0] ldResTag,
    output logic [31:0] ldResult,
    output logic ldFail,

    input  logic stValid,
    input  logic [lsuConfigPkg::addrWidth-1:0] stAddr,
    input  logic [31:0] stData,
    input  logic [3:0] stMask,
    input  logic [lsuConfigPkg::idWidth-1:0] stId,

    output logic stAckValid,
    output logic [lsuConfigPkg::idWidth-1:0] stAckId,
    output logic stAckFail,

    output lsuTypesPkg::memCmd memCmd,
    output logic [lsuConfigPkg::defLineIdWidth-1:0] memCacheLine,
    output logic [lsuConfigPkg::addrWidth-1:0] memReadAddr,
    output logic [lsuConfigPkg::addrWidth-1:0] memWriteAddr,

    input  logic memStall,
    input  logic fillEn,
    input  logic [lsuConfigPkg::defWordIdxWidth-1:0] fillWordIdx,
    input  logic [31:0] fillData,
    input  logic memDone
);

    import lsuConfigPkg::*;

    localparam int numWays = defNumWays;
    localparam int numSets = defNumSets;
    localparam int lineWords = defLineWords;

    // load read port
    logic ldRdEn;
    logic [defIndexWidth+defWordIdxWidth-1:0] ldRdAddr;
    logic [numWays-1:0][defTagWidth-1:0] ldTags;
    logic [numWays-1:0] ldTagValid;
    logic [numWays-1:0][31:0] ldWords;

    // store read port
    logic stRdEn;
    logic [defIndexWidth-1:0] stRdAddr;
    logic [numWays-1:0][defTagWidth-1:0] stTags;
    logic [numWays-1:0] stTagValid;

    // victim lookup and tag install
    logic [defIndexWidth-1:0] vicSet, tagSet;
    logic [defWayWidth-1:0] vicWay, tagWay;
    logic [defTagWidth-1:0] vicTag, tagValue;
    logic vicValid, vicDirty, tagWe;

    // store write
    logic dataWe;
    logic [defIndexWidth-1:0] dataSet;
    logic [defWayWidth-1:0] dataWay;
    logic [defWordIdxWidth-1:0] dataWordIdx;
    logic [31:0] dataWrite;
    logic [3:0] dataMask;

    // transfer status
    logic xferValid;
    logic [defLineAddrWidth-1:0] xferLine;
    logic [defWayWidth-1:0] fillWay;
    logic [defIndexWidth-1:0] fillSet;

    logic ldMissValid, stMissValid;
    logic [addrWidth-1:0] ldMissAddr, stMissAddr;

    cacheArrays #(
        .numWays(numWays),
        .numSets(numSets),
        .lineWords(lineWords)
    ) arrays (
        .clk(clk), .rst(rst),
        .ldRdEn(ldRdEn), .ldRdAddr(ldRdAddr),
        .ldTags(ldTags), .ldTagValid(ldTagValid), .ldWords(ldWords),
        .stRdEn(stRdEn), .stRdAddr(stRdAddr),
        .stTags(stTags), .stTagValid(stTagValid),
        .vicSet(vicSet), .vicWay(vicWay),
        .vicTag(vicTag), .vicValid(vicValid), .vicDirty(vicDirty),
        .tagWe(tagWe), .tagSet(tagSet), .tagWay(tagWay), .tagValue(tagValue),
        .dataWe(dataWe), .dataSet(dataSet), .dataWay(dataWay),
        .dataWordIdx(dataWordIdx), .dataWrite(dataWrite), .dataMask(dataMask),
        .fillEn(fillEn), .fillWay(fillWay), .fillSet(fillSet),
        .fillWordIdx(fillWordIdx), .fillData(fillData)
    );

    loadPipe #(
        .numWays(numWays),
        .numSets(numSets),
        .lineWords(lineWords)
    ) ldPipe (
        .clk(clk), .rst(rst),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldSize(ldSize),
        .ldSigned(ldSigned), .ldTag(ldTag),
        .rdEn(ldRdEn), .rdAddr(ldRdAddr),
        .tags(ldTags), .tagValid(ldTagValid), .words(ldWords),
        .xferValid(xferValid), .xferLine(xferLine),
        .ldResValid(ldResValid), .ldResTag(ldResTag),
        .ldResult(ldResult), .ldFail(ldFail),
        .missValid(ldMissValid), .missAddr(ldMissAddr)
    );

    storePipe #(
        .numWays(numWays),
        .numSets(numSets),
        .lineWords(lineWords)
    ) stPipe (
        .clk(clk), .rst(rst),
        .stValid(stValid), .stAddr(stAddr), .stData(stData),
        .stMask(stMask), .stId(stId),
        .rdEn(stRdEn), .rdAddr(stRdAddr),
        .tags(stTags), .tagValid(stTagValid),
        .xferValid(xferValid), .xferLine(xferLine),
        .dataWe(dataWe), .dataSet(dataSet), .dataWay(dataWay),
        .dataWordIdx(dataWordIdx), .dataWrite(dataWrite), .dataMask(dataMask),
        .stAckValid(stAckValid), .stAckId(stAckId), .stAckFail(stAckFail),
        .missValid(stMissValid), .missAddr(stMissAddr)
    );

    missArbiter #(
        .numWays(numWays),
        .numSets(numSets),
        .lineWords(lineWords)
    ) arbiter (
        .clk(clk), .rst(rst),
        .ldMissValid(ldMissValid), .ldMissAddr(ldMissAddr),
        .stMissValid(stMissValid), .stMissAddr(stMissAddr),
        .vicSet(vicSet), .vicWay(vicWay),
        .vicTag(vicTag), .vicValid(vicValid), .vicDirty(vicDirty),
        .tagWe(tagWe), .tagSet(tagSet), .tagWay(tagWay), .tagValue(tagValue),
        .xferValid(xferValid), .xferLine(xferLine),
        .fillWay(fillWay), .fillSet(fillSet),
        .memCmd(memCmd), .memCacheLine(memCacheLine),
        .memReadAddr(memReadAddr), .memWriteAddr(memWriteAddr),
        .memStall(memStall), .memDone(memDone)
    );

endmodule

// File: tests/cacheLsu_checker.sv
`timescale 1ns/1ns

module cacheLsuChecker (
    input  logic clk,
    input  logic rst,
    input  lsuTypesPkg::memCmd memCmd,
    input  logic memStall,
    input  logic ldResValid,
    input  logic ldFail,
    input  lsuTypesPkg::arbState state
);

    import lsuTypesPkg::*;

    // a pending command holds while the controller stalls
    cmdHoldsUnderStall: assert property (
        @(posedge clk) disable iff (rst)
        memStall && memCmd != cmdNone |=> $stable(memCmd)
    ) else $error("memCmd changed while memStall was high");

    // a load either returns data or fails, never both
    resultOrFail: assert property (
        @(posedge clk) disable iff (rst)
        !(ldResValid && ldFail)
    ) else $error("ldResValid and ldFail were high in the same cycle");

    // new commands only come out of the idle state
    cmdStartsFromIdle: assert property (
        @(posedge clk) disable iff (rst)
        memCmd != cmdNone && $past(memCmd) == cmdNone |-> $past(state) == idle
    ) else $error("a memory command started while the arbiter was busy");

endmodule

// File: tests/cacheLsuTb.sv
`timescale 1ns/1ns

module cacheLsuTb;

    import lsuConfigPkg::*;
    import lsuTypesPkg::*;

    localparam int vecFields = 10;
    localparam int maxVecs = 64;
    localparam int endOp = 'hF;

    logic clk;
    logic rst;

    logic ldValid;
    logic [addrWidth-1:0] ldAddr;
    lsuTypesPkg::ldSize ldSize;
    logic ldSigned;
    logic [idWidth-1:0] ldTag;
    logic ldResValid;
    logic [idWidth-1:0] ldResTag;
    logic [31:0] ldResult;
    logic ldFail;

    logic stValid;
    logic [addrWidth-1:0] stAddr;
    logic [31:0] stData;
    logic [3:0] stMask;
    logic [idWidth-1:0] stId;
    logic stAckValid;
    logic [idWidth-1:0] stAckId;
    logic stAckFail;

    lsuTypesPkg::memCmd memCmd;
    logic [defLineIdWidth-1:0] memCacheLine;
    logic [addrWidth-1:0] memReadAddr;
    logic [addrWidth-1:0] memWriteAddr;
    logic memStall;
    logic fillEn;
    logic [defWordIdxWidth-1:0] fillWordIdx;
    logic [31:0] fillData;
    logic memDone;

    logic [31:0] vecMem [vecFields*maxVecs];
    int numVecs = 0;
    logic vecsReady = 1'b0;
    int seed = 44752;

    // way the round-robin victim counter should pick for the next transfer
    logic [defWayWidth-1:0] nextVictimWay;

    cacheLsu uut (
        .clk(clk), .rst(rst),
        .ldValid(ldValid), .ldAddr(ldAddr), .ldSize(ldSize),
        .ldSigned(ldSigned), .ldTag(ldTag),
        .ldResValid(ldResValid), .ldResTag(ldResTag),
        .ldResult(ldResult), .ldFail(ldFail),
        .stValid(stValid), .stAddr(stAddr), .stData(stData),
        .stMask(stMask), .stId(stId),
        .stAckValid(stAckValid), .stAckId(stAckId), .stAckFail(stAckFail),
        .memCmd(memCmd), .memCacheLine(memCacheLine),
        .memReadAddr(memReadAddr), .memWriteAddr(memWriteAddr),
        .memStall(memStall), .fillEn(fillEn), .fillWordIdx(fillWordIdx),
        .fillData(fillData), .memDone(memDone)
    );

    bind cacheLsu cacheLsuChecker lsuChk (
        .clk(clk), .rst(rst), .memCmd(memCmd), .memStall(memStall),
        .ldResValid(ldResValid), .ldFail(ldFail), .state(arbiter.state)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected)
        else abortRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    endtask

    function automatic int pickStallCycles();
        return $unsigned($random(seed)) % 4;
    endfunction

    // controller side of a transfer where every word holds its own address inverted
    task automatic fillLine(input logic [31:0] lineAddr);
        for (int i = 0; i < defLineWords; i++) begin
            fillEn <= 1'b1;
            fillWordIdx <= defWordIdxWidth'(i);
            fillData <= ~(lineAddr + 32'(4 * i));
            @(posedge clk);
        end
        fillEn <= 1'b0;
        memDone <= 1'b1;
        @(posedge clk);
        memDone <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // one operation every 4 cycles, starting and ending on a rising edge
    task automatic runVector(input int v);
        logic [31:0] op, addr, data, mask, size, sgn;
        logic [31:0] expFail, expVal, expCmd, expAddr;
        logic isLoad, isStore;
        lsuTypesPkg::memCmd cmdExp;
        string name;
        op = vecMem[v*vecFields];
        addr = vecMem[v*vecFields + 1];
        data = vecMem[v*vecFields + 2];
        mask = vecMem[v*vecFields + 3];
        size = vecMem[v*vecFields + 4];
        sgn = vecMem[v*vecFields + 5];
        expFail = vecMem[v*vecFields + 6];
        expVal = vecMem[v*vecFields + 7];
        expCmd = vecMem[v*vecFields + 8];
        expAddr = vecMem[v*vecFields + 9];
        name = $sformatf("vector %0d", v);
        isLoad = op == 1 || op == 3;
        isStore = op == 2 || op == 3;
        case (expCmd)
            1: cmdExp = cmdReplace;
            2: cmdExp = cmdCopyIn;
            default: cmdExp = cmdNone;
        endcase

        if (isLoad) begin
            ldValid <= 1'b1;
            ldAddr <= addr;
            ldSize <= lsuTypesPkg::ldSize'(size[1:0]);
            ldSigned <= sgn[0];
            ldTag <= v[7:0];
        end
        if (isStore) begin
            stValid <= 1'b1;
            // the combined operation carries the store address in the data column
            stAddr <= (op == 3) ? data : addr;
            stData <= (op == 3) ? 32'h0 : data;
            stMask <= mask[3:0];
            stId <= v[7:0];
        end
        @(posedge clk);
        ldValid <= 1'b0;
        stValid <= 1'b0;
        @(posedge clk);
        @(negedge clk);

        // response cycle t+2
        if (isLoad) begin
            checkValue({name, " ldFail"}, expFail, 32'(ldFail));
            checkValue({name, " ldResValid"}, 32'(!expFail[0]), 32'(ldResValid));
            checkValue({name, " ldResTag"}, 32'(v[7:0]), 32'(ldResTag));
            if (!expFail[0]) begin
                checkValue({name, " ldResult"}, expVal, ldResult);
            end
        end
        if (isStore) begin
            checkValue({name, " stAckValid"}, 32'd1, 32'(stAckValid));
            checkValue({name, " stAckFail"}, expFail, 32'(stAckFail));
            checkValue({name, " stAckId"}, 32'(v[7:0]), 32'(stAckId));
        end
        @(posedge clk);
        @(negedge clk);

        // a miss shows its command in t+3, and holds it while stalled
        if (op != 0) begin
            checkValue({name, " memCmd"}, 32'(cmdExp), 32'(memCmd));
            if (cmdExp != cmdNone) begin
                // cache line number is the victim way above the set of the miss
                checkValue({name, " memCacheLine"},
                    32'({nextVictimWay, expAddr[defOffsetWidth +: defIndexWidth]}),
                    32'(memCacheLine));
                nextVictimWay = nextVictimWay + 1'b1;
            end
            if (cmdExp == cmdReplace) begin
                checkValue({name, " memWriteAddr"}, expAddr, memWriteAddr);
                // the refill still fetches the missing line
                checkValue({name, " memReadAddr"},
                    addr & ~(32'(defLineWords * 4) - 32'd1), memReadAddr);
            end
            if (cmdExp == cmdCopyIn) begin
                checkValue({name, " memReadAddr"}, expAddr, memReadAddr);
            end
        end
        @(posedge clk);
    endtask

    // memory controller model
    initial begin
        int stallLeft;
        logic [31:0] lineAddr;
        logic cmdSeen;
        logic stallSeen;
        memDone = 1'b0;
        fillEn = 1'b0;
        fillWordIdx = '0;
        fillData = '0;
        stallLeft = pickStallCycles();
        memStall = stallLeft != 0;
        forever begin
            @(negedge clk);
            cmdSeen = !rst && memCmd != cmdNone;
            stallSeen = memStall;
            lineAddr = memReadAddr;
            @(posedge clk);
            if (cmdSeen && stallSeen) begin
                stallLeft = stallLeft - 1;
                memStall <= stallLeft != 0;
            end else if (cmdSeen) begin
                fillLine(lineAddr);
                stallLeft = pickStallCycles();
                memStall <= stallLeft != 0;
            end
        end
    end

    initial begin
        wait (vecsReady);
        repeat (numVecs * 40) @(posedge clk);
        abortRun($sformatf("Timeout: the run did not finish within %0d cycles", numVecs * 40));
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        ldValid = 1'b0;
        ldAddr = '0;
        ldSize = sizeByte;
        ldSigned = 1'b0;
        ldTag = '0;
        stValid = 1'b0;
        stAddr = '0;
        stData = '0;
        stMask = '0;
        stId = '0;
        nextVictimWay = '0;

        $readmemh("tests/cacheLsuVectors.txt", vecMem);
        while (numVecs < maxVecs && vecMem[numVecs*vecFields] !== endOp) begin
            numVecs++;
        end
        if (numVecs == 0 || numVecs == maxVecs) begin
            abortRun("Vector file is missing, empty or has no end marker");
        end
        vecsReady = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int v = 0; v < numVecs; v++) begin
            runVector(v);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: tests/cacheLsuVectors.txt
// op addr data mask size signed expFail expValue expCmd expCmdAddr
// op 0 idle, 1 load, 2 store, 3 load and store (data = store address), f end
// size 0 byte, 1 half, 2 word; expCmd 0 none, 1 replace (write-back addr), 2 copy-in (read addr)
// first touch of a line misses, then a load to it during the refill
1 00001010 00000000 0 2 0 1 00000000 2 00001010
1 00001014 00000000 0 2 0 1 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
// word, byte and half loads from the filled line
1 00001014 00000000 0 2 0 0 FFFFEFEB 0 00000000
1 00001011 00000000 0 0 1 0 FFFFFFEF 0 00000000
1 00001012 00000000 0 0 0 0 000000FF 0 00000000
1 00001018 00000000 0 1 1 0 FFFFEFE7 0 00000000
1 00001018 00000000 0 1 0 0 0000EFE7 0 00000000
// masked store hit, then read back the merged word
2 0000101C 12345678 3 0 0 0 00000000 0 00000000
1 0000101C 00000000 0 2 0 0 FFFF5678 0 00000000
1 0000101C 00000000 0 0 1 0 00000078 0 00000000
// other way of set 1
1 00002010 00000000 0 2 0 1 00000000 2 00002010
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
1 00002010 00000000 0 2 0 0 FFFFDFEF 0 00000000
// dirty victim is written back, store to the line in transfer fails
1 00003010 00000000 0 2 0 1 00000000 1 00001010
2 00003014 AAAAAAAA F 0 0 1 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
1 00003018 00000000 0 2 0 0 FFFFCFE7 0 00000000
// clean victim only needs a copy-in
1 0000101C 00000000 0 2 0 1 00000000 2 00001010
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
1 0000101C 00000000 0 2 0 0 FFFFEFE3 0 00000000
// load and store miss together, only the load line is fetched
3 00004020 00005030 F 2 0 1 00000000 2 00004020
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
1 00004020 00000000 0 2 0 0 FFFFBFDF 0 00000000
2 00005030 11111111 F 0 0 1 00000000 2 00005030
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
0 00000000 00000000 0 0 0 0 00000000 0 00000000
2 00005030 A5A5A5A5 F 0 0 0 00000000 0 00000000
1 00005031 00000000 0 0 0 0 000000A5 0 00000000
1 00005030 00000000 0 2 0 0 A5A5A5A5 0 00000000
F 00000000 00000000 0 0 0 0 00000000 0 00000000

// File: cacheLsu.f
logic/lsuConfigPkg.sv
logic/lsuTypesPkg.sv
logic/cacheArrays.sv
logic/loadPipe.sv
logic/storePipe.sv
logic/missArbiter.sv
logic/cacheLsu.sv
tests/cacheLsu_checker.sv
tests/cacheLsuTb.sv

// File: Bender.yml
package:
  name: cacheLsu

sources:
  - logic/lsuConfigPkg.sv
  - logic/lsuTypesPkg.sv
  - logic/cacheArrays.sv
  - logic/loadPipe.sv
  - logic/storePipe.sv
  - logic/missArbiter.sv
  - logic/cacheLsu.sv
  - target: test
    files:
      - tests/cacheLsu_checker.sv
      - tests/cacheLsuTb.sv
